//--- sources.f
src/wh_pkg.sv
src/wh_flit_fifo.sv
src/wh_adapter_in.sv
src/wh_adapter_out.sv
src/wh_router_adapter.sv
testbench/tb_clk_gen.sv
testbench/tb_wh_adapter.sv

//--- Makefile
SIM      := verilator
TOP      := tb_wh_adapter
FILELIST := sources.f
FLAGS    := --binary --assert --timescale 1ns/1ps -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell cat $(FILELIST))
PASS_MSG := Simulation passed

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_wh_adapter.sv
`timescale 1ns/1ps

module tb_wh_adapter;
  import wh_pkg::*;

  localparam int timeout_c = 200;  // cycles per wait
  localparam logic [31:0] seed_c = 32'h204d_f04a;

  logic                    clk_w;
  logic                    rst_n_w;
  wh_packet_s              in_packet;
  logic                    in_v;
  logic                    in_ready;
  wh_link_s                link_rx;  // router to DUT
  wh_link_s                link_tx;  // DUT to router
  wh_packet_s              out_packet;
  logic                    out_v;
  logic                    out_yumi;

  logic                    rtr_full;
  logic [flit_width_c-1:0] rtr_data;
  logic                    stall_en;
  int                      flit_count;
  int                      check_count;
  int                      error_count;
  wh_packet_s              sent_q[$];

  tb_clk_gen u_clk_gen (
    .clk_o  (clk_w),
    .rst_n_o(rst_n_w)
  );

  wh_router_adapter #(
    .els_p(2)
  ) u_dut (
    .clk_i   (clk_w),
    .rst_n_i (rst_n_w),
    .packet_i(in_packet),
    .v_i     (in_v),
    .ready_o (in_ready),
    .link_i  (link_rx),
    .link_o  (link_tx),
    .packet_o(out_packet),
    .v_o     (out_v),
    .yumi_i  (out_yumi)
  );

  // one-flit router register, loops link_o back onto link_i
  initial begin
    logic                    take;
    logic                    give;
    logic                    stall;
    logic [flit_width_c-1:0] data;
    rtr_full   = 1'b0;
    rtr_data   = '0;
    flit_count = 0;
    link_rx    = '{v: 1'b0, ready_and_rev: 1'b1, data: '0};
    forever begin
      @(negedge clk_w);
      take  = link_rx.ready_and_rev & link_tx.v;
      give  = link_rx.v & link_tx.ready_and_rev;
      data  = link_tx.data;
      stall = stall_en && ($urandom_range(3, 0) == 0);
      @(posedge clk_w);
      #1;
      if (give) rtr_full = 1'b0;
      if (take) begin
        rtr_full = 1'b1;
        rtr_data = data;
        flit_count++;
      end
      link_rx = '{v: rtr_full, ready_and_rev: !rtr_full && !stall, data: rtr_data};
    end
  end

  task automatic next_drive();
    @(posedge clk_w);
    #1;
  endtask

  task automatic expect_true(input logic ok, input string what);
    check_count++;
    assert (ok) else begin
      error_count++;
      $display("Fail %0t: %s", $time, what);
    end
  endtask

  task automatic report_timeout(input string what);
    error_count++;
    $display("Timeout at %0t ns: %s", $time, what);
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) $display("%s: ok", name);
    else $display("%s: %0d errors", name, error_count - errors_before);
  endtask

  function automatic wh_packet_s random_packet(input int len);
    wh_packet_s  pkt;
    logic [95:0] bits;
    bits        = {$urandom(), $urandom(), $urandom()};
    pkt.cord    = cord_width_c'($urandom());
    pkt.len     = len_width_c'(len);
    pkt.payload = bits[max_payload_width_c-1:0];
    return pkt;
  endfunction

  // only the flits that travel survive, everything above is zero
  function automatic wh_packet_s truncate_packet(input wh_packet_s pkt);
    logic [packet_width_c-1:0] bits;
    int                        kept;
    bits = pkt;
    kept = flit_width_c * (int'(pkt.len) + 1);
    for (int i = 0; i < packet_width_c; i++) begin
      if (i >= kept) bits[i] = 1'b0;
    end
    return bits;
  endfunction

  task automatic send_packet(input wh_packet_s pkt);
    int   waited;
    logic taken;
    waited    = 0;
    taken     = 1'b0;
    in_packet = pkt;
    in_v      = 1'b1;
    while (!taken && waited < timeout_c) begin
      @(negedge clk_w);
      taken = in_ready;
      next_drive();
      waited++;
    end
    in_v = 1'b0;
    if (taken) sent_q.push_back(truncate_packet(pkt));
    else report_timeout("ready_o never rose to take a packet");
  endtask

  task automatic receive_packet(input int hold_max);
    int         waited;
    int         hold;
    logic       seen;
    wh_packet_s got;
    wh_packet_s exp;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < timeout_c) begin
      @(negedge clk_w);
      seen = out_v;
      got  = out_packet;
      waited++;
    end
    if (!seen) begin
      report_timeout("no packet came out on packet_o");
    end else begin
      expect_true(sent_q.size() != 0, "v_o rose with no packet expected");
      if (sent_q.size() != 0) begin
        exp = sent_q.pop_front();
        expect_true(got == exp, $sformatf("packet %h, expected %h", got, exp));
      end
      hold = (hold_max > 0) ? int'($urandom_range(hold_max, 0)) : 0;
      next_drive();
      repeat (hold) next_drive();  // client keeps the link side waiting
      out_yumi = 1'b1;
      next_drive();
      out_yumi = 1'b0;
    end
  endtask

  task automatic test_reset_values();
    int errors_before;
    errors_before = error_count;
    @(negedge clk_w);
    expect_true(in_ready === 1'b1, "ready_o not high after reset");
    expect_true(out_v === 1'b0, "v_o not low after reset");
    expect_true(link_tx.v === 1'b0, "link_o.v not low after reset");
    expect_true(link_tx.ready_and_rev === 1'b1, "link_o.ready_and_rev not high after reset");
    next_drive();
    report_test("reset values", errors_before);
  endtask

  task automatic test_full_length();
    int errors_before;
    int flits_before;
    errors_before = error_count;
    flits_before  = flit_count;
    send_packet(random_packet(3));
    receive_packet(0);
    expect_true(flit_count - flits_before == 4,
                $sformatf("%0d flits on link_o, expected 4", flit_count - flits_before));
    report_test("full length packet", errors_before);
  endtask

  task automatic test_short_lengths();
    int errors_before;
    errors_before = error_count;
    for (int len = 0; len < 3; len++) begin
      send_packet(random_packet(len));
      receive_packet(0);
    end
    report_test("short packets", errors_before);
  endtask

  task automatic test_stalled_stream();
    int errors_before;
    errors_before = error_count;
    stall_en      = 1'b1;
    fork
      begin
        for (int i = 0; i < 10; i++) begin
          repeat ($urandom_range(2, 0)) next_drive();
          send_packet(random_packet(int'($urandom_range(max_len_c, 0))));
        end
      end
      begin
        for (int i = 0; i < 10; i++) receive_packet(6);
      end
    join
    stall_en = 1'b0;
    report_test("stalled stream", errors_before);
  endtask

  task automatic test_back_to_back();
    int   errors_before;
    logic extra;
    errors_before = error_count;
    extra         = 1'b0;
    fork
      begin
        for (int i = 0; i < 20; i++) begin
          send_packet(random_packet(int'($urandom_range(max_len_c, 0))));
        end
      end
      begin
        for (int i = 0; i < 20; i++) receive_packet(0);
      end
    join
    repeat (20) begin
      @(negedge clk_w);
      if (out_v) extra = 1'b1;
    end
    expect_true(!extra, "v_o pulsed with no packet left to deliver");
    expect_true(sent_q.size() == 0, $sformatf("%0d packets never came back", sent_q.size()));
    next_drive();
    report_test("back to back", errors_before);
  endtask

  initial begin
    int waited;
    void'($urandom(seed_c));
    in_packet   = '0;
    in_v        = 1'b0;
    out_yumi    = 1'b0;
    stall_en    = 1'b0;
    check_count = 0;
    error_count = 0;
    waited      = 0;
    while (rst_n_w !== 1'b1 && waited < 20) begin
      @(negedge clk_w);
      waited++;
    end
    if (rst_n_w !== 1'b1) report_timeout("reset was never released");
    next_drive();

    test_reset_values();
    test_full_length();
    test_short_lengths();
    test_stalled_stream();
    test_back_to_back();

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int half_period_p  = 2,
  parameter int reset_cycles_p = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(half_period_p) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (reset_cycles_p) @(posedge clk_o);
    #1 rst_n_o = 1'b1;  // released with the other inputs
  end

endmodule

//--- src/wh_router_adapter.sv
`timescale 1ns/1ps

module wh_router_adapter #(
  parameter int els_p = 2
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  wh_pkg::wh_packet_s packet_i,
  input  logic               v_i,
  output logic               ready_o,
  input  wh_pkg::wh_link_s   link_i,    // from the router
  output wh_pkg::wh_link_s   link_o,    // to the router
  output wh_pkg::wh_packet_s packet_o,
  output logic               v_o,
  input  logic               yumi_i
);
  import wh_pkg::*;

  logic [flit_width_c-1:0] in_data;
  logic                    in_v;
  logic                    out_ready;

  // serializer owns the forward half of link_o
  wh_adapter_in u_adapter_in (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .packet_i    (packet_i),
    .v_i         (v_i),
    .ready_o     (ready_o),
    .link_data_o (in_data),
    .link_v_o    (in_v),
    .link_ready_i(link_i.ready_and_rev)
  );

  wh_adapter_out #(
    .els_p(els_p)
  ) u_adapter_out (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .link_data_i (link_i.data),
    .link_v_i    (link_i.v),
    .link_ready_o(out_ready),
    .packet_o    (packet_o),
    .v_o         (v_o),
    .yumi_i      (yumi_i)
  );

  // ready_and_rev answers the router's flits, not ours
  assign link_o = '{
    v:             in_v,
    ready_and_rev: out_ready,
    data:          in_data
  };

endmodule

//--- src/wh_adapter_out.sv
`timescale 1ns/1ps

module wh_adapter_out #(
  parameter int els_p = 2
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic [wh_pkg::flit_width_c-1:0] link_data_i,
  input  logic                            link_v_i,
  output logic                            link_ready_o,
  output wh_pkg::wh_packet_s              packet_o,
  output logic                            v_o,
  input  logic                            yumi_i
);
  import wh_pkg::*;

  wh_out_state_e state_r;

  logic [max_flits_c-1:0][flit_width_c-1:0] flits_r;
  logic [cnt_width_c-1:0]                   cnt_r;
  logic [cnt_width_c-1:0]                   len_r;
  logic [len_width_c-1:0]                   hdr_len;
  logic [flit_width_c-1:0]                  fifo_data;
  logic                                     fifo_push;
  logic                                     fifo_v;
  logic                                     fifo_pop;

  assign fifo_push = link_v_i & link_ready_o;

  wh_flit_fifo #(
    .els_p(els_p)
  ) u_fifo (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .data_i (link_data_i),
    .v_i    (fifo_push),
    .ready_o(link_ready_o),
    .data_o (fifo_data),
    .v_o    (fifo_v),
    .yumi_i (fifo_pop)
  );

  // buffer keeps filling while the finished packet waits
  assign fifo_pop = fifo_v & (state_r != out_full);
  assign hdr_len  = fifo_data[cord_width_c +: len_width_c];

  assign v_o      = (state_r == out_full);
  assign packet_o = packet_width_c'(flits_r);

  // slices beyond len stay zero from the header clear
  always_ff @(posedge clk_i) begin
    if (fifo_pop) begin
      if (state_r == out_header) begin
        flits_r    <= '0;
        flits_r[0] <= fifo_data;
      end else begin
        flits_r[cnt_r] <= fifo_data;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= out_header;
      cnt_r   <= '0;
      len_r   <= '0;
    end else begin
      case (state_r)
        out_header: begin
          if (fifo_pop) begin
            len_r   <= hdr_len[cnt_width_c-1:0];
            cnt_r   <= cnt_width_c'(1);  // first body slice
            state_r <= (hdr_len == '0) ? out_full : out_body;
          end
        end
        out_body: begin
          if (fifo_pop) begin
            if (cnt_r == len_r) begin
              state_r <= out_full;
            end else begin
              cnt_r <= cnt_r + 1'b1;
            end
          end
        end
        out_full: begin
          if (yumi_i) begin
            state_r <= out_header;
          end
        end
        default: begin
          state_r <= out_header;
        end
      endcase
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) yumi_i |-> v_o)
    else $error("wh_adapter_out: yumi_i without v_o");

endmodule

//--- src/wh_adapter_in.sv
`timescale 1ns/1ps

module wh_adapter_in (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  wh_pkg::wh_packet_s              packet_i,
  input  logic                            v_i,
  output logic                            ready_o,
  output logic [wh_pkg::flit_width_c-1:0] link_data_o,
  output logic                            link_v_o,
  input  logic                            link_ready_i
);
  import wh_pkg::*;

  wh_in_state_e state_r;
  wh_packet_s   packet_r;

  logic [cnt_width_c-1:0]                   cnt_r;
  logic [max_flits_c-1:0][flit_width_c-1:0] flits_w;
  logic                                     accept;
  logic                                     flit_sent;
  logic                                     last_flit;

  assign ready_o   = (state_r == in_idle);
  assign accept    = v_i & ready_o;
  assign link_v_o  = (state_r == in_send);
  assign flit_sent = link_v_o & link_ready_i;

  // bits above the packet go out as zero
  assign flits_w     = (max_flits_c * flit_width_c)'(packet_r);
  assign link_data_o = flits_w[cnt_r];

  // header counts as flit zero, so the last one has index len
  assign last_flit = (cnt_r == packet_r.len[cnt_width_c-1:0]);

  always_ff @(posedge clk_i) begin
    if (accept) begin
      packet_r <= packet_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= in_idle;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        in_idle: begin
          if (accept) begin
            state_r <= in_send;
            cnt_r   <= '0;
          end
        end
        in_send: begin
          if (flit_sent) begin
            if (last_flit) begin
              state_r <= in_idle;  // ready again next cycle
            end else begin
              cnt_r <= cnt_r + 1'b1;
            end
          end
        end
        default: begin
          state_r <= in_idle;
        end
      endcase
    end
  end

  // a longer packet would index past the slices we hold
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accept |-> (packet_i.len <= len_width_c'(max_len_c)))
    else $error("wh_adapter_in: length %0d above %0d", packet_i.len, max_len_c);

endmodule

//--- src/wh_flit_fifo.sv
`timescale 1ns/1ps

module wh_flit_fifo #(
  parameter int els_p = 2
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic [wh_pkg::flit_width_c-1:0] data_i,
  input  logic                            v_i,
  output logic                            ready_o,
  output logic [wh_pkg::flit_width_c-1:0] data_o,
  output logic                            v_o,
  input  logic                            yumi_i
);
  import wh_pkg::*;

  localparam int ptr_width_lc = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_width_lc = $clog2(els_p + 1);

  logic [flit_width_c-1:0] mem_r [els_p];
  logic [ptr_width_lc-1:0] wr_ptr_r;
  logic [ptr_width_lc-1:0] rd_ptr_r;
  logic [cnt_width_lc-1:0] count_r;

  function automatic logic [ptr_width_lc-1:0] ptr_next(input logic [ptr_width_lc-1:0] ptr);
    if (ptr == ptr_width_lc'(els_p - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign ready_o = (count_r != cnt_width_lc'(els_p));
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];  // head is visible the cycle after the write

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (v_i) wr_ptr_r <= ptr_next(wr_ptr_r);
      if (yumi_i) rd_ptr_r <= ptr_next(rd_ptr_r);
      case ({v_i, yumi_i})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;  // idle or push and pop together
      endcase
    end
  end

  // the writer must gate its valid with our ready
  assert property (@(posedge clk_i) disable iff (!rst_n_i) v_i |-> ready_o)
    else $error("wh_flit_fifo: write while full");

  assert property (@(posedge clk_i) disable iff (!rst_n_i) yumi_i |-> v_o)
    else $error("wh_flit_fifo: pop while empty");

endmodule

//--- src/wh_pkg.sv
package wh_pkg;

  // link and packet geometry
  localparam int flit_width_c        = 32;
  localparam int cord_width_c        = 8;
  localparam int len_width_c         = 4;
  localparam int max_payload_width_c = 88;
  localparam int packet_width_c      = cord_width_c + len_width_c + max_payload_width_c;

  // flits needed for a full packet, header included
  localparam int max_flits_c = (packet_width_c + flit_width_c - 1) / flit_width_c;
  localparam int max_len_c   = max_flits_c - 1;   // body flits after the header
  localparam int cnt_width_c = $clog2(max_flits_c);

  // cord sits in the low bits, payload on top
  typedef struct packed {
    logic [max_payload_width_c-1:0] payload;
    logic [len_width_c-1:0]         len;
    logic [cord_width_c-1:0]        cord;
  } wh_packet_s;

  // one direction of a ready/valid link
  typedef struct packed {
    logic                    v;
    logic                    ready_and_rev;  // ready for the opposite direction
    logic [flit_width_c-1:0] data;
  } wh_link_s;

  typedef enum logic {
    in_idle,
    in_send
  } wh_in_state_e;

  typedef enum logic [1:0] {
    out_header,
    out_body,
    out_full
  } wh_out_state_e;

endpackage
